//--- design/udp_stack_pkg.sv
// Types and constants shared by the UDP layer switch
// The UDP header travels big-endian in one 64-bit beat with byte lane 0 first
package udp_stack_pkg;

    typedef logic [63:0] data_t;
    typedef logic [7:0]  keep_t;

    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    typedef struct packed {
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    localparam logic [7:0]  IP_PROTO_UDP = 8'h11;
    localparam logic [15:0] IP_HDR_BYTES = 16'd20;

    // Most significant byte of a packed header goes to lane 0 and back
    function automatic data_t swap_bytes(data_t d);
        data_t r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = d[63-8*i -: 8];
        end
        return r;
    endfunction

endpackage

//--- design/ip_frame_if.sv
// IP frame carried as a header stream and a 64-bit payload stream
// Each frame has exactly one header and its payload ends at tlast
`timescale 1ns/1ps

interface ip_frame_if
    import udp_stack_pkg::*;
();

    logic    hdr_valid;
    logic    hdr_ready;
    ip_hdr_t hdr;
    data_t   tdata;
    keep_t   tkeep;
    logic    tvalid;
    logic    tready;
    logic    tlast;
    logic    tuser;

    modport src (
        output hdr_valid, hdr, tdata, tkeep, tvalid, tlast, tuser,
        input  hdr_ready, tready
    );

    modport snk (
        input  hdr_valid, hdr, tdata, tkeep, tvalid, tlast, tuser,
        output hdr_ready, tready
    );

endinterface

//--- design/ip_rx_demux.sv
// Steers received IP frames by protocol number
// UDP frames go to the UDP receiver and all others to the raw output
// One frame at a time so the next header waits for the current tlast
`timescale 1ns/1ps

module ip_rx_demux
    import udp_stack_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    ip_frame_if.snk in,
    ip_frame_if.src udp,
    ip_frame_if.src raw
);

    logic is_udp;
    logic busy_q;
    logic sel_udp_q;

    assign is_udp = (in.hdr.protocol == IP_PROTO_UDP);

    // Payload route fixed at header accept, released after last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q    <= 1'b0;
            sel_udp_q <= 1'b0;
        end else if (in.hdr_valid && in.hdr_ready) begin
            busy_q    <= 1'b1;
            sel_udp_q <= is_udp;
        end else if (in.tvalid && in.tready && in.tlast) begin
            busy_q <= 1'b0;
        end
    end

    assign udp.hdr_valid = in.hdr_valid && !busy_q && is_udp;
    assign raw.hdr_valid = in.hdr_valid && !busy_q && !is_udp;
    assign udp.hdr       = in.hdr;
    assign raw.hdr       = in.hdr;
    assign in.hdr_ready  = !busy_q && (is_udp ? udp.hdr_ready : raw.hdr_ready);

    assign udp.tvalid = in.tvalid && busy_q && sel_udp_q;
    assign raw.tvalid = in.tvalid && busy_q && !sel_udp_q;
    assign in.tready  = busy_q && (sel_udp_q ? udp.tready : raw.tready);

    assign udp.tdata = in.tdata;
    assign udp.tkeep = in.tkeep;
    assign udp.tlast = in.tlast;
    assign udp.tuser = in.tuser;
    assign raw.tdata = in.tdata;
    assign raw.tkeep = in.tkeep;
    assign raw.tlast = in.tlast;
    assign raw.tuser = in.tuser;

    // Route depends on a protocol held until the header is taken
    assert property (@(posedge clk) disable iff (rst)
        in.hdr_valid && !in.hdr_ready |=> in.hdr_valid && $stable(in.hdr.protocol));

endmodule

//--- design/udp_rx.sv
// Takes the 8-byte UDP header from the first payload beat of an IP frame
// Payload beats pass combinationally once the UDP header is accepted
// A header beat with tlast drops the frame and pulses early termination
`timescale 1ns/1ps

module udp_rx
    import udp_stack_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    ip_frame_if.snk  ip,
    output logic     m_udp_hdr_valid,
    input  logic     m_udp_hdr_ready,
    output ip_hdr_t  m_udp_ip_hdr,
    output udp_hdr_t m_udp_hdr,
    output data_t    m_udp_tdata,
    output keep_t    m_udp_tkeep,
    output logic     m_udp_tvalid,
    input  logic     m_udp_tready,
    output logic     m_udp_tlast,
    output logic     m_udp_tuser,
    output logic     header_early_termination
);

    typedef enum logic [1:0] {ST_HDR, ST_WAIT, ST_PAYLOAD} state_t;

    state_t   state;
    logic     ip_hdr_held;
    logic     err_q;
    logic     beat_take;
    ip_hdr_t  ip_hdr_q;
    udp_hdr_t udp_hdr_q;

    assign ip.hdr_ready = (state == ST_HDR) && !ip_hdr_held;
    assign ip.tready    = (state == ST_HDR) ? ip_hdr_held :
                          ((state == ST_PAYLOAD) && m_udp_tready);
    assign beat_take    = ip.tvalid && ip.tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_HDR;
            ip_hdr_held <= 1'b0;
            err_q       <= 1'b0;
        end else begin
            err_q <= 1'b0;
            case (state)
                ST_HDR: begin
                    if (ip.hdr_valid && ip.hdr_ready) begin
                        ip_hdr_held <= 1'b1;
                    end
                    if (beat_take) begin
                        ip_hdr_held <= 1'b0;
                        if (ip.tlast) begin
                            err_q <= 1'b1;
                        end else begin
                            state <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT: begin
                    if (m_udp_hdr_ready) begin
                        state <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat_take && ip.tlast) begin
                        state <= ST_HDR;
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ip.hdr_valid && ip.hdr_ready) begin
            ip_hdr_q <= ip.hdr;
        end
        if ((state == ST_HDR) && beat_take) begin
            udp_hdr_q <= udp_hdr_t'(swap_bytes(ip.tdata));
        end
    end

    assign m_udp_hdr_valid          = (state == ST_WAIT);
    assign m_udp_ip_hdr             = ip_hdr_q;
    assign m_udp_hdr                = udp_hdr_q;
    assign m_udp_tdata              = ip.tdata;
    assign m_udp_tkeep              = ip.tkeep;
    assign m_udp_tvalid             = (state == ST_PAYLOAD) && ip.tvalid;
    assign m_udp_tlast              = ip.tlast;
    assign m_udp_tuser              = ip.tuser;
    assign header_early_termination = err_q;

    // Stalled payload beat holds until taken
    assert property (@(posedge clk) disable iff (rst)
        m_udp_tvalid && !m_udp_tready |=>
            m_udp_tvalid && $stable({m_udp_tdata, m_udp_tkeep, m_udp_tlast}));

endmodule

//--- design/udp_tx.sv
// Wraps a UDP header and payload into an IP frame with protocol 0x11
// The UDP header goes out as the first beat and its checksum is untouched
// Payload must hold at least one beat
`timescale 1ns/1ps

module udp_tx
    import udp_stack_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     s_udp_hdr_valid,
    output logic     s_udp_hdr_ready,
    input  ip_hdr_t  s_udp_ip_hdr,
    input  udp_hdr_t s_udp_hdr,
    input  data_t    s_udp_tdata,
    input  keep_t    s_udp_tkeep,
    input  logic     s_udp_tvalid,
    output logic     s_udp_tready,
    input  logic     s_udp_tlast,
    input  logic     s_udp_tuser,
    ip_frame_if.src  ip
);

    typedef enum logic [1:0] {ST_IDLE, ST_IP_HDR, ST_BEAT, ST_PAYLOAD} state_t;

    state_t   state;
    ip_hdr_t  ip_hdr_q;
    udp_hdr_t udp_hdr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:    if (s_udp_hdr_valid) state <= ST_IP_HDR;
                ST_IP_HDR:  if (ip.hdr_ready) state <= ST_BEAT;
                ST_BEAT:    if (ip.tready) state <= ST_PAYLOAD;
                ST_PAYLOAD: if (s_udp_tvalid && ip.tready && s_udp_tlast) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Protocol and length of the incoming IP fields are replaced
    always_ff @(posedge clk) begin
        if (s_udp_hdr_valid && s_udp_hdr_ready) begin
            ip_hdr_q          <= s_udp_ip_hdr;
            ip_hdr_q.protocol <= IP_PROTO_UDP;
            ip_hdr_q.length   <= s_udp_hdr.length + IP_HDR_BYTES;
            udp_hdr_q         <= s_udp_hdr;
        end
    end

    assign s_udp_hdr_ready = (state == ST_IDLE);
    assign s_udp_tready    = (state == ST_PAYLOAD) && ip.tready;

    assign ip.hdr_valid = (state == ST_IP_HDR);
    assign ip.hdr       = ip_hdr_q;
    assign ip.tvalid    = (state == ST_BEAT) || ((state == ST_PAYLOAD) && s_udp_tvalid);
    assign ip.tdata     = (state == ST_BEAT) ? swap_bytes(udp_hdr_q) : s_udp_tdata;
    assign ip.tkeep     = (state == ST_BEAT) ? 8'hff : s_udp_tkeep;
    assign ip.tlast     = (state == ST_BEAT) ? 1'b0 : s_udp_tlast;
    assign ip.tuser     = (state == ST_BEAT) ? 1'b0 : s_udp_tuser;

endmodule

//--- design/ip_tx_arbiter.sv
// Fixed-priority frame arbiter with the lowest index first
// A grant holds from the header through the payload tlast
// Granted payload moves only after its header is accepted
`timescale 1ns/1ps

module ip_tx_arbiter
    import udp_stack_pkg::*;
#(
    parameter int PORTS = 2
) (
    input  logic    clk,
    input  logic    rst,
    ip_frame_if.snk src [PORTS],
    ip_frame_if.src out
);

    logic [PORTS-1:0] req;
    logic [PORTS-1:0] pick;
    logic [PORTS-1:0] grant_q;
    logic [PORTS-1:0] tvalid_v;
    logic [PORTS-1:0] tlast_v;
    logic [PORTS-1:0] tuser_v;
    logic             hdr_done_q;
    ip_hdr_t          hdr_v [PORTS];
    data_t            tdata_v [PORTS];
    keep_t            tkeep_v [PORTS];

    for (genvar i = 0; i < PORTS; i++) begin : g_port
        assign req[i]           = src[i].hdr_valid;
        assign hdr_v[i]         = src[i].hdr;
        assign tdata_v[i]       = src[i].tdata;
        assign tkeep_v[i]       = src[i].tkeep;
        assign tvalid_v[i]      = src[i].tvalid;
        assign tlast_v[i]       = src[i].tlast;
        assign tuser_v[i]       = src[i].tuser;
        assign src[i].hdr_ready = grant_q[i] && !hdr_done_q && out.hdr_ready;
        assign src[i].tready    = grant_q[i] && hdr_done_q && out.tready;
    end

    // Lowest set request bit
    assign pick = req & (~req + 1'b1);

    always_comb begin
        out.hdr   = '0;
        out.tdata = '0;
        out.tkeep = '0;
        for (int i = 0; i < PORTS; i++) begin
            if (grant_q[i]) begin
                out.hdr   = hdr_v[i];
                out.tdata = tdata_v[i];
                out.tkeep = tkeep_v[i];
            end
        end
    end

    assign out.hdr_valid = |(grant_q & req) && !hdr_done_q;
    assign out.tvalid    = |(grant_q & tvalid_v) && hdr_done_q;
    assign out.tlast     = |(grant_q & tlast_v);
    assign out.tuser     = |(grant_q & tuser_v);

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q    <= '0;
            hdr_done_q <= 1'b0;
        end else if (grant_q == '0) begin
            grant_q <= pick;
        end else if (!hdr_done_q) begin
            hdr_done_q <= out.hdr_valid && out.hdr_ready;
        end else if (out.tvalid && out.tready && out.tlast) begin
            grant_q    <= '0;
            hdr_done_q <= 1'b0;
        end
    end

    // A granted header holds until the bus takes it
    assert property (@(posedge clk) disable iff (rst)
        out.hdr_valid && !out.hdr_ready |=> out.hdr_valid && $stable(out.hdr));

endmodule

//--- design/udp_complete.sv
// UDP and raw IP switch for a 64-bit frame stack
// UDP checksums pass through and are never generated
// Transmit port 0 is UDP and port 1 is raw IP, with port 0 winning
// Built for ARB_PORTS of 2
`timescale 1ns/1ps

module udp_complete
    import udp_stack_pkg::*;
#(
    parameter int ARB_PORTS = 2
) (
    input  logic     clk,
    input  logic     rst,
    // Received IP frames
    input  logic     ip_rx_hdr_valid,
    output logic     ip_rx_hdr_ready,
    input  ip_hdr_t  ip_rx_hdr,
    input  data_t    ip_rx_tdata,
    input  keep_t    ip_rx_tkeep,
    input  logic     ip_rx_tvalid,
    output logic     ip_rx_tready,
    input  logic     ip_rx_tlast,
    input  logic     ip_rx_tuser,
    // Received frames other than UDP
    output logic     m_ip_hdr_valid,
    input  logic     m_ip_hdr_ready,
    output ip_hdr_t  m_ip_hdr,
    output data_t    m_ip_tdata,
    output keep_t    m_ip_tkeep,
    output logic     m_ip_tvalid,
    input  logic     m_ip_tready,
    output logic     m_ip_tlast,
    output logic     m_ip_tuser,
    output logic     m_udp_hdr_valid,
    input  logic     m_udp_hdr_ready,
    output ip_hdr_t  m_udp_ip_hdr,
    output udp_hdr_t m_udp_hdr,
    output data_t    m_udp_tdata,
    output keep_t    m_udp_tkeep,
    output logic     m_udp_tvalid,
    input  logic     m_udp_tready,
    output logic     m_udp_tlast,
    output logic     m_udp_tuser,
    input  logic     s_udp_hdr_valid,
    output logic     s_udp_hdr_ready,
    input  ip_hdr_t  s_udp_ip_hdr,
    input  udp_hdr_t s_udp_hdr,
    input  data_t    s_udp_tdata,
    input  keep_t    s_udp_tkeep,
    input  logic     s_udp_tvalid,
    output logic     s_udp_tready,
    input  logic     s_udp_tlast,
    input  logic     s_udp_tuser,
    // Raw IP transmit
    input  logic     s_ip_hdr_valid,
    output logic     s_ip_hdr_ready,
    input  ip_hdr_t  s_ip_hdr,
    input  data_t    s_ip_tdata,
    input  keep_t    s_ip_tkeep,
    input  logic     s_ip_tvalid,
    output logic     s_ip_tready,
    input  logic     s_ip_tlast,
    input  logic     s_ip_tuser,
    // Shared IP transmit bus
    output logic     ip_tx_hdr_valid,
    input  logic     ip_tx_hdr_ready,
    output ip_hdr_t  ip_tx_hdr,
    output data_t    ip_tx_tdata,
    output keep_t    ip_tx_tkeep,
    output logic     ip_tx_tvalid,
    input  logic     ip_tx_tready,
    output logic     ip_tx_tlast,
    output logic     ip_tx_tuser,
    output logic     udp_rx_error_header_early_termination
);

    ip_frame_if ip_rx_bus ();
    ip_frame_if rx_udp ();
    ip_frame_if rx_raw ();
    ip_frame_if tx_src [ARB_PORTS] ();
    ip_frame_if ip_tx_bus ();

    assign ip_rx_bus.hdr_valid = ip_rx_hdr_valid;
    assign ip_rx_bus.hdr       = ip_rx_hdr;
    assign ip_rx_bus.tdata     = ip_rx_tdata;
    assign ip_rx_bus.tkeep     = ip_rx_tkeep;
    assign ip_rx_bus.tvalid    = ip_rx_tvalid;
    assign ip_rx_bus.tlast     = ip_rx_tlast;
    assign ip_rx_bus.tuser     = ip_rx_tuser;
    assign ip_rx_hdr_ready     = ip_rx_bus.hdr_ready;
    assign ip_rx_tready        = ip_rx_bus.tready;

    assign m_ip_hdr_valid   = rx_raw.hdr_valid;
    assign m_ip_hdr         = rx_raw.hdr;
    assign m_ip_tdata       = rx_raw.tdata;
    assign m_ip_tkeep       = rx_raw.tkeep;
    assign m_ip_tvalid      = rx_raw.tvalid;
    assign m_ip_tlast       = rx_raw.tlast;
    assign m_ip_tuser       = rx_raw.tuser;
    assign rx_raw.hdr_ready = m_ip_hdr_ready;
    assign rx_raw.tready    = m_ip_tready;

    assign tx_src[1].hdr_valid = s_ip_hdr_valid;
    assign tx_src[1].hdr       = s_ip_hdr;
    assign tx_src[1].tdata     = s_ip_tdata;
    assign tx_src[1].tkeep     = s_ip_tkeep;
    assign tx_src[1].tvalid    = s_ip_tvalid;
    assign tx_src[1].tlast     = s_ip_tlast;
    assign tx_src[1].tuser     = s_ip_tuser;
    assign s_ip_hdr_ready      = tx_src[1].hdr_ready;
    assign s_ip_tready         = tx_src[1].tready;

    assign ip_tx_hdr_valid     = ip_tx_bus.hdr_valid;
    assign ip_tx_hdr           = ip_tx_bus.hdr;
    assign ip_tx_tdata         = ip_tx_bus.tdata;
    assign ip_tx_tkeep         = ip_tx_bus.tkeep;
    assign ip_tx_tvalid        = ip_tx_bus.tvalid;
    assign ip_tx_tlast         = ip_tx_bus.tlast;
    assign ip_tx_tuser         = ip_tx_bus.tuser;
    assign ip_tx_bus.hdr_ready = ip_tx_hdr_ready;
    assign ip_tx_bus.tready    = ip_tx_tready;

    ip_rx_demux u_demux (
        .clk (clk),
        .rst (rst),
        .in  (ip_rx_bus),
        .udp (rx_udp),
        .raw (rx_raw)
    );

    // Remaining m_udp ports match by name
    udp_rx u_udp_rx (
        .ip                       (rx_udp),
        .header_early_termination (udp_rx_error_header_early_termination),
        .*
    );

    udp_tx u_udp_tx (
        .ip (tx_src[0]),
        .*
    );

    ip_tx_arbiter #(
        .PORTS (ARB_PORTS)
    ) u_arbiter (
        .clk (clk),
        .rst (rst),
        .src (tx_src),
        .out (ip_tx_bus)
    );

endmodule

//--- testbench/udp_complete_checker.sv
// Watches the DUT outputs and compares them with the frames that the testbench expects
// Outputs are sampled on the falling edge, where valid and ready are settled
// Transmit frames are matched to their source by protocol number
`timescale 1ns/1ps

module udp_complete_checker
    import udp_stack_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     m_udp_hdr_valid,
    input logic     m_udp_hdr_ready,
    input ip_hdr_t  m_udp_ip_hdr,
    input udp_hdr_t m_udp_hdr,
    input data_t    m_udp_tdata,
    input keep_t    m_udp_tkeep,
    input logic     m_udp_tvalid,
    input logic     m_udp_tready,
    input logic     m_udp_tlast,
    input logic     m_udp_tuser,
    input logic     m_ip_hdr_valid,
    input logic     m_ip_hdr_ready,
    input ip_hdr_t  m_ip_hdr,
    input data_t    m_ip_tdata,
    input keep_t    m_ip_tkeep,
    input logic     m_ip_tvalid,
    input logic     m_ip_tready,
    input logic     m_ip_tlast,
    input logic     m_ip_tuser,
    input logic     ip_tx_hdr_valid,
    input logic     ip_tx_hdr_ready,
    input ip_hdr_t  ip_tx_hdr,
    input data_t    ip_tx_tdata,
    input keep_t    ip_tx_tkeep,
    input logic     ip_tx_tvalid,
    input logic     ip_tx_tready,
    input logic     ip_tx_tlast,
    input logic     ip_tx_tuser,
    input logic     udp_rx_error_header_early_termination
);

    // Beat entry is {tuser, tlast, tkeep, tdata}
    typedef logic [73:0] beat_t;

    ip_hdr_t  q_udp_ip[$];
    udp_hdr_t q_udp_hdr[$];
    beat_t    q_udp_beat[$];
    ip_hdr_t  q_raw_hdr[$];
    beat_t    q_raw_beat[$];
    ip_hdr_t  q_txu_hdr[$];
    beat_t    q_txu_beat[$];
    ip_hdr_t  q_txr_hdr[$];
    beat_t    q_txr_beat[$];
    int       errors = 0;
    int       early_count = 0;
    logic     tx_busy = 1'b0;
    logic     tx_is_udp = 1'b0;

    task automatic expect_udp_hdr(input ip_hdr_t h, input udp_hdr_t u);
        q_udp_ip.push_back(h);
        q_udp_hdr.push_back(u);
    endtask

    task automatic expect_udp_beat(input beat_t b);
        q_udp_beat.push_back(b);
    endtask

    task automatic expect_raw_hdr(input ip_hdr_t h);
        q_raw_hdr.push_back(h);
    endtask

    task automatic expect_raw_beat(input beat_t b);
        q_raw_beat.push_back(b);
    endtask

    task automatic expect_tx(input logic udp, input ip_hdr_t h);
        if (udp) q_txu_hdr.push_back(h);
        else q_txr_hdr.push_back(h);
    endtask

    task automatic expect_tx_beat(input logic udp, input beat_t b);
        if (udp) q_txu_beat.push_back(b);
        else q_txr_beat.push_back(b);
    endtask

    function automatic int pending();
        return q_udp_ip.size() + q_udp_beat.size() + q_raw_hdr.size() + q_raw_beat.size()
            + q_txu_hdr.size() + q_txu_beat.size() + q_txr_hdr.size() + q_txr_beat.size();
    endfunction

    task automatic compare(input string name, input logic [103:0] got, input logic [103:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_beat(input string name, ref beat_t q[$], input beat_t got);
        if (q.size() == 0) begin
            errors++;
            $display("Unexpected payload beat on %s at %0t", name, $time);
        end else begin
            compare({name, "_beat"}, 104'(got), 104'(q.pop_front()));
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                if (q_udp_ip.size() == 0) begin
                    errors++;
                    $display("Unexpected header on m_udp at %0t", $time);
                end else begin
                    compare("m_udp_ip_hdr", m_udp_ip_hdr, q_udp_ip.pop_front());
                    compare("m_udp_hdr", 104'(m_udp_hdr), 104'(q_udp_hdr.pop_front()));
                end
            end
            if (m_udp_tvalid && m_udp_tready) begin
                check_beat("m_udp", q_udp_beat,
                           {m_udp_tuser, m_udp_tlast, m_udp_tkeep, m_udp_tdata});
            end
            if (m_ip_hdr_valid && m_ip_hdr_ready) begin
                if (q_raw_hdr.size() == 0) begin
                    errors++;
                    $display("Unexpected header on m_ip at %0t", $time);
                end else begin
                    compare("m_ip_hdr", m_ip_hdr, q_raw_hdr.pop_front());
                end
            end
            if (m_ip_tvalid && m_ip_tready) begin
                check_beat("m_ip", q_raw_beat, {m_ip_tuser, m_ip_tlast, m_ip_tkeep, m_ip_tdata});
            end
            if (ip_tx_hdr_valid && ip_tx_hdr_ready) begin
                tx_is_udp = (ip_tx_hdr.protocol == IP_PROTO_UDP);
                if (tx_busy) begin
                    errors++;
                    $display("New header on ip_tx before the previous frame ended at %0t", $time);
                end
                if ((tx_is_udp ? q_txu_hdr.size() : q_txr_hdr.size()) == 0) begin
                    errors++;
                    $display("Unexpected header on ip_tx at %0t", $time);
                end else if (tx_is_udp) begin
                    compare("ip_tx_hdr", ip_tx_hdr, q_txu_hdr.pop_front());
                end else begin
                    compare("ip_tx_hdr", ip_tx_hdr, q_txr_hdr.pop_front());
                end
                tx_busy = 1'b1;
            end
            if (ip_tx_tvalid && ip_tx_tready) begin
                if (!tx_busy) begin
                    errors++;
                    $display("Payload beat on ip_tx without a header at %0t", $time);
                end else if (tx_is_udp) begin
                    check_beat("ip_tx", q_txu_beat,
                               {ip_tx_tuser, ip_tx_tlast, ip_tx_tkeep, ip_tx_tdata});
                end else begin
                    check_beat("ip_tx", q_txr_beat,
                               {ip_tx_tuser, ip_tx_tlast, ip_tx_tkeep, ip_tx_tdata});
                end
                if (ip_tx_tlast) tx_busy = 1'b0;
            end
            if (udp_rx_error_header_early_termination) early_count++;
        end
    end

endmodule

//--- testbench/tb_udp_complete.sv
// Testbench for the UDP and raw IP switch
// Directed frames first, then concurrent traffic with random back-pressure
// Every payload holds at least one beat
`timescale 1ns/1ps

module tb_udp_complete;
    import udp_stack_pkg::*;

    localparam int FRAMES = 30;

    logic     clk = 1'b0;
    logic     rst;
    logic     stress = 1'b0;
    int       early_expected = 0;
    int       tb_errors = 0;
    ip_hdr_t  ip_rx_hdr, m_ip_hdr, m_udp_ip_hdr, s_udp_ip_hdr, s_ip_hdr, ip_tx_hdr;
    udp_hdr_t m_udp_hdr, s_udp_hdr;
    data_t    ip_rx_tdata, m_ip_tdata, m_udp_tdata, s_udp_tdata, s_ip_tdata, ip_tx_tdata;
    keep_t    ip_rx_tkeep, m_ip_tkeep, m_udp_tkeep, s_udp_tkeep, s_ip_tkeep, ip_tx_tkeep;
    logic     ip_rx_hdr_valid, ip_rx_hdr_ready, ip_rx_tvalid, ip_rx_tready;
    logic     ip_rx_tlast, ip_rx_tuser;
    logic     m_ip_hdr_valid, m_ip_hdr_ready, m_ip_tvalid, m_ip_tready, m_ip_tlast, m_ip_tuser;
    logic     m_udp_hdr_valid, m_udp_hdr_ready, m_udp_tvalid, m_udp_tready;
    logic     m_udp_tlast, m_udp_tuser;
    logic     s_udp_hdr_valid, s_udp_hdr_ready, s_udp_tvalid, s_udp_tready;
    logic     s_udp_tlast, s_udp_tuser;
    logic     s_ip_hdr_valid, s_ip_hdr_ready, s_ip_tvalid, s_ip_tready, s_ip_tlast, s_ip_tuser;
    logic     ip_tx_hdr_valid, ip_tx_hdr_ready, ip_tx_tvalid, ip_tx_tready;
    logic     ip_tx_tlast, ip_tx_tuser;
    logic     udp_rx_error_header_early_termination;

    udp_complete #(.ARB_PORTS(2)) DUT (.*);
    udp_complete_checker chk (.*);

    always #5 clk = ~clk;

    // Reference: UDP header packed big-endian, source port high byte in lane 0
    function automatic data_t header_beat(udp_hdr_t u);
        return {u.checksum[7:0], u.checksum[15:8], u.length[7:0], u.length[15:8],
                u.dest_port[7:0], u.dest_port[15:8], u.source_port[7:0], u.source_port[15:8]};
    endfunction

    // Reference: IP header built for a transmitted UDP frame
    function automatic ip_hdr_t tx_ip_hdr(ip_hdr_t h, udp_hdr_t u);
        h.protocol = 8'h11;
        h.length   = u.length + 16'd20;
        return h;
    endfunction

    function automatic ip_hdr_t rand_ip_hdr(logic [7:0] proto);
        ip_hdr_t h;
        h = ip_hdr_t'({$urandom, $urandom, $urandom, $urandom});
        h.protocol = proto;
        return h;
    endfunction

    function automatic logic [7:0] raw_proto();
        logic [7:0] p;
        p = 8'($urandom);
        return (p == IP_PROTO_UDP) ? 8'h06 : p;
    endfunction

    function automatic keep_t beat_keep(logic last);
        return last ? keep_t'(8'hff >> ($urandom % 8)) : 8'hff;
    endfunction

    task automatic send_rx(input logic udp, input int n);
        ip_hdr_t  h;
        udp_hdr_t u;
        logic     ok;
        h = rand_ip_hdr(udp ? IP_PROTO_UDP : raw_proto());
        u = udp_hdr_t'({$urandom, $urandom});
        if (!udp) chk.expect_raw_hdr(h);
        else if (n > 1) chk.expect_udp_hdr(h, u);
        else early_expected++;
        ip_rx_hdr = h;
        ip_rx_hdr_valid = 1'b1;
        do begin
            @(negedge clk);
            ok = ip_rx_hdr_ready;
            @(posedge clk);
            #1;
        end while (!ok);
        ip_rx_hdr_valid = 1'b0;
        for (int i = 0; i < n; i++) begin
            ip_rx_tlast = (i == n - 1);
            ip_rx_tdata = (udp && i == 0) ? header_beat(u) : {$urandom, $urandom};
            ip_rx_tkeep = (udp && i == 0) ? 8'hff : beat_keep(ip_rx_tlast);
            ip_rx_tuser = (udp && i == 0) ? 1'b0 : 1'($urandom);
            if (!udp) begin
                chk.expect_raw_beat({ip_rx_tuser, ip_rx_tlast, ip_rx_tkeep, ip_rx_tdata});
            end else if (i > 0) begin
                chk.expect_udp_beat({ip_rx_tuser, ip_rx_tlast, ip_rx_tkeep, ip_rx_tdata});
            end
            ip_rx_tvalid = 1'b1;
            do begin
                @(negedge clk);
                ok = ip_rx_tready;
                @(posedge clk);
                #1;
            end while (!ok);
        end
        ip_rx_tvalid = 1'b0;
    endtask

    task automatic send_udp(input int n);
        ip_hdr_t  h;
        udp_hdr_t u;
        logic     ok;
        h = rand_ip_hdr(8'($urandom));
        u = udp_hdr_t'({$urandom, $urandom});
        chk.expect_tx(1'b1, tx_ip_hdr(h, u));
        chk.expect_tx_beat(1'b1, {1'b0, 1'b0, 8'hff, header_beat(u)});
        s_udp_ip_hdr = h;
        s_udp_hdr = u;
        s_udp_hdr_valid = 1'b1;
        do begin
            @(negedge clk);
            ok = s_udp_hdr_ready;
            @(posedge clk);
            #1;
        end while (!ok);
        s_udp_hdr_valid = 1'b0;
        for (int i = 0; i < n; i++) begin
            s_udp_tlast = (i == n - 1);
            s_udp_tdata = {$urandom, $urandom};
            s_udp_tkeep = beat_keep(s_udp_tlast);
            s_udp_tuser = 1'($urandom);
            chk.expect_tx_beat(1'b1, {s_udp_tuser, s_udp_tlast, s_udp_tkeep, s_udp_tdata});
            s_udp_tvalid = 1'b1;
            do begin
                @(negedge clk);
                ok = s_udp_tready;
                @(posedge clk);
                #1;
            end while (!ok);
        end
        s_udp_tvalid = 1'b0;
    endtask

    task automatic send_raw(input int n);
        ip_hdr_t h;
        logic    ok;
        h = rand_ip_hdr(raw_proto());
        chk.expect_tx(1'b0, h);
        s_ip_hdr = h;
        s_ip_hdr_valid = 1'b1;
        do begin
            @(negedge clk);
            ok = s_ip_hdr_ready;
            @(posedge clk);
            #1;
        end while (!ok);
        s_ip_hdr_valid = 1'b0;
        for (int i = 0; i < n; i++) begin
            s_ip_tlast = (i == n - 1);
            s_ip_tdata = {$urandom, $urandom};
            s_ip_tkeep = beat_keep(s_ip_tlast);
            s_ip_tuser = 1'($urandom);
            chk.expect_tx_beat(1'b0, {s_ip_tuser, s_ip_tlast, s_ip_tkeep, s_ip_tdata});
            s_ip_tvalid = 1'b1;
            do begin
                @(negedge clk);
                ok = s_ip_tready;
                @(posedge clk);
                #1;
            end while (!ok);
        end
        s_ip_tvalid = 1'b0;
    endtask

    // Output readies, toggled at random once traffic runs concurrently
    always @(posedge clk) begin
        #1;
        m_udp_hdr_ready = !stress || $urandom % 2;
        m_udp_tready    = !stress || $urandom % 2;
        m_ip_hdr_ready  = !stress || $urandom % 2;
        m_ip_tready     = !stress || $urandom % 2;
        ip_tx_hdr_ready = !stress || $urandom % 2;
        ip_tx_tready    = !stress || $urandom % 2;
    end

    initial begin
        repeat (200 * FRAMES) @(posedge clk);
        $display("Timeout after %0d cycles with frames still in flight", 200 * FRAMES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(32'h7acc_abf3));
        rst = 1'b1;
        {ip_rx_hdr_valid, ip_rx_tvalid, ip_rx_tlast, ip_rx_tuser} = '0;
        {s_udp_hdr_valid, s_udp_tvalid, s_udp_tlast, s_udp_tuser} = '0;
        {s_ip_hdr_valid, s_ip_tvalid, s_ip_tlast, s_ip_tuser} = '0;
        {ip_rx_hdr, ip_rx_tdata, ip_rx_tkeep, s_ip_hdr, s_ip_tdata, s_ip_tkeep} = '0;
        {s_udp_ip_hdr, s_udp_hdr, s_udp_tdata, s_udp_tkeep} = '0;
        {m_udp_hdr_ready, m_udp_tready, m_ip_hdr_ready, m_ip_tready} = '1;
        {ip_tx_hdr_ready, ip_tx_tready} = '1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        send_rx(1'b1, 4);
        send_rx(1'b0, 3);
        send_rx(1'b1, 1);
        send_udp(3);
        send_raw(2);
        send_udp(1);
        stress = 1'b1;
        fork
            repeat (8) send_rx($urandom % 3 != 0, 1 + $urandom % 5);
            repeat (8) send_udp(1 + $urandom % 5);
            repeat (8) send_raw(1 + $urandom % 5);
        join
        while (chk.pending() != 0) @(posedge clk);
        repeat (10) @(posedge clk);
        if (chk.early_count != early_expected) begin
            tb_errors++;
            $display("Early termination seen %0d times where %0d were expected",
                     chk.early_count, early_expected);
        end
        $display("Errors: checker %0d, testbench %0d", chk.errors, tb_errors);
        if (chk.errors + tb_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- udp_complete.f
design/udp_stack_pkg.sv
design/ip_frame_if.sv
design/ip_rx_demux.sv
design/udp_rx.sv
design/udp_tx.sv
design/ip_tx_arbiter.sv
design/udp_complete.sv
testbench/udp_complete_checker.sv
testbench/tb_udp_complete.sv
